// ==== rtl/sdmac_pkg.sv ====
// SCSI DMA controller shared definitions
// Bus widths, control and status bundles, cycle FSM encoding
package sdmac_pkg;

    localparam int DATA_W     = 8;
    localparam int LWORD_W    = 32;
    localparam int REG_ADDR_W = 4;

    // Byte lanes per FIFO longword and the offset counter width
    localparam int LANES = LWORD_W / DATA_W;
    localparam int BO_W  = $clog2(LANES);

    // Strobes to the external SCSI chip, all active high
    typedef struct packed {
        logic                  cs;
        logic                  re;
        logic                  we;
        logic                  dack;
        logic [REG_ADDR_W-1:0] addr;
    } scsi_bus_t;

    // Datapath steering and pointer control from the FSM
    typedef struct packed {
        logic s2f;
        logic f2s;
        logic s2cpu;
        logic cpu2s;
        logic inc_bo;
        logic inc_ni;
        logic inc_no;
    } dp_ctl_t;

    typedef struct packed {
        logic full;
        logic empty;
        logic bo_eq3;
    } fifo_stat_t;

    // IDLE is encoded as all ones except the lowest bit
    typedef enum logic [4:0] {
        IDLE     = 5'b11110,
        CPU_ACC  = 5'b00001,
        CPU_ACK  = 5'b00010,
        CPU_WAIT = 5'b00100,
        DMA_ACC  = 5'b01000,
        DMA_REC  = 5'b10000
    } sm_state_e;

endpackage

// ==== rtl/scsi_sm.sv ====
// SCSI cycle sequencer
// Arbitrates CPU register accesses and DMA byte cycles onto the chip bus
`timescale 1ns/1ns

module scsi_sm #(
    parameter int ACCESS_CYCLES = 3
) (
    input  logic                                BCLK,
    input  logic                                CRESET_,
    input  logic                                cpu_req_i,
    input  logic                                cpu_rw_i,
    input  logic [sdmac_pkg::REG_ADDR_W-1:0]    cpu_addr_i,
    input  logic                                dma_dir_i,
    input  logic                                dreq_n_i,
    input  sdmac_pkg::fifo_stat_t               fifo_stat_i,
    output sdmac_pkg::scsi_bus_t                scsi_bus_o,
    output sdmac_pkg::dp_ctl_t                  dp_ctl_o,
    output logic                                set_dsack_o
);

    localparam int CNT_W = $clog2(ACCESS_CYCLES + 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(ACCESS_CYCLES - 1);

    sdmac_pkg::sm_state_e state_q;
    sdmac_pkg::sm_state_e nxt_state;

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] nxt_cnt;

    // Synchronised requests
    logic cpu_req_q;
    logic dreq_n_q;

    logic acc_done;
    logic acc_last;
    logic dma_go;

    sdmac_pkg::scsi_bus_t bus_d;
    sdmac_pkg::dp_ctl_t   ctl_d;
    logic                 dsack_d;

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cpu_req_q <= 1'b0;
            dreq_n_q  <= 1'b1;
        end else begin
            cpu_req_q <= cpu_req_i;
            dreq_n_q  <= dreq_n_i;
        end
    end

    assign acc_done = (cnt_q == LAST_CNT);

    // DMA byte allowed only when the FIFO has room or data for it
    assign dma_go = !dreq_n_q &&
                    (dma_dir_i ? !fifo_stat_i.empty : !fifo_stat_i.full);

    always_comb begin
        nxt_state = state_q;
        nxt_cnt   = '0;
        case (state_q)
            sdmac_pkg::IDLE: begin
                // CPU wins when both are pending
                if (cpu_req_q) begin
                    nxt_state = sdmac_pkg::CPU_ACC;
                end else if (dma_go) begin
                    nxt_state = sdmac_pkg::DMA_ACC;
                end
            end
            sdmac_pkg::CPU_ACC: begin
                if (acc_done) begin
                    nxt_state = sdmac_pkg::CPU_ACK;
                end else begin
                    nxt_cnt = cnt_q + 1'b1;
                end
            end
            sdmac_pkg::CPU_ACK: nxt_state = sdmac_pkg::CPU_WAIT;
            sdmac_pkg::CPU_WAIT: begin
                // Hold off until the CPU has released its request
                if (!cpu_req_q) begin
                    nxt_state = sdmac_pkg::IDLE;
                end
            end
            sdmac_pkg::DMA_ACC: begin
                if (acc_done) begin
                    nxt_state = sdmac_pkg::DMA_REC;
                end else begin
                    nxt_cnt = cnt_q + 1'b1;
                end
            end
            sdmac_pkg::DMA_REC: nxt_state = sdmac_pkg::IDLE;
            default: nxt_state = sdmac_pkg::IDLE;
        endcase
    end

    // Strobes are decoded from the next state so they register with it
    assign acc_last = (nxt_cnt == LAST_CNT);

    always_comb begin
        bus_d = '0;
        ctl_d = '0;
        case (nxt_state)
            sdmac_pkg::CPU_ACC: begin
                bus_d.cs    = 1'b1;
                bus_d.re    = cpu_rw_i;
                bus_d.we    = !cpu_rw_i;
                bus_d.addr  = cpu_addr_i;
                ctl_d.cpu2s = !cpu_rw_i;
                ctl_d.s2cpu = cpu_rw_i && acc_last;
            end
            sdmac_pkg::DMA_ACC: begin
                bus_d.dack   = 1'b1;
                bus_d.re     = !dma_dir_i;
                bus_d.we     = dma_dir_i;
                ctl_d.f2s    = dma_dir_i;
                // Byte moves on the last strobe cycle
                ctl_d.s2f    = !dma_dir_i && acc_last;
                ctl_d.inc_bo = acc_last;
                ctl_d.inc_ni = !dma_dir_i && acc_last && fifo_stat_i.bo_eq3;
                ctl_d.inc_no = dma_dir_i && acc_last && fifo_stat_i.bo_eq3;
            end
            default: begin
                bus_d = '0;
                ctl_d = '0;
            end
        endcase
    end

    // Read data was latched on the way into CPU_ACK
    assign dsack_d = (state_q == sdmac_pkg::CPU_ACK);

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state_q     <= sdmac_pkg::IDLE;
            cnt_q       <= '0;
            scsi_bus_o  <= '0;
            dp_ctl_o    <= '0;
            set_dsack_o <= 1'b0;
        end else begin
            state_q     <= nxt_state;
            cnt_q       <= nxt_cnt;
            scsi_bus_o  <= bus_d;
            dp_ctl_o    <= ctl_d;
            set_dsack_o <= dsack_d;
        end
    end

    // Only one chip cycle on the shared bus at a time
    a_cs_dack_excl: assert property (
        @(posedge BCLK) disable iff (!CRESET_)
        !(scsi_bus_o.cs && scsi_bus_o.dack)
    );

    a_dsack_pulse: assert property (
        @(posedge BCLK) disable iff (!CRESET_)
        set_dsack_o |=> !set_dsack_o
    );

    a_s2f_not_full: assert property (
        @(posedge BCLK) disable iff (!CRESET_)
        $rose(dp_ctl_o.s2f) |-> !fifo_stat_i.full
    );

endmodule

// ==== rtl/sdmac_datapath.sv ====
// SCSI DMA datapath
// Longword FIFO, byte offset pointer and CPU/chip byte steering
`timescale 1ns/1ns

module sdmac_datapath #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             BCLK,
    input  logic                             CRESET_,
    input  sdmac_pkg::dp_ctl_t               dp_ctl_i,
    input  logic [sdmac_pkg::DATA_W-1:0]     scsi_d_i,
    input  logic [sdmac_pkg::DATA_W-1:0]     cpu_d_i,
    input  logic                             mem_wr_i,
    input  logic [sdmac_pkg::LWORD_W-1:0]    mem_wdata_i,
    input  logic                             mem_rd_i,
    output logic [sdmac_pkg::DATA_W-1:0]     scsi_d_o,
    output logic [sdmac_pkg::DATA_W-1:0]     cpu_d_o,
    output logic [sdmac_pkg::LWORD_W-1:0]    mem_rdata_o,
    output sdmac_pkg::fifo_stat_t            fifo_stat_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [sdmac_pkg::LWORD_W-1:0] fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]              wr_ptr_q;
    logic [PTR_W-1:0]              rd_ptr_q;
    logic [CNT_W-1:0]              count_q;
    logic [sdmac_pkg::BO_W-1:0]    bo_q;

    logic [sdmac_pkg::LWORD_W-1:0] pack_q;
    logic [sdmac_pkg::LWORD_W-1:0] pack_nxt;
    logic [sdmac_pkg::LWORD_W-1:0] head;
    logic [sdmac_pkg::LWORD_W-1:0] push_data;
    logic [sdmac_pkg::DATA_W-1:0]  cpu_d_q;
    logic [sdmac_pkg::DATA_W-1:0]  lane_byte;
    int unsigned                   lane_ofs;

    logic full;
    logic empty;
    logic push;
    logic pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty = (count_q == '0);
    assign head  = fifo_mem[rd_ptr_q];

    // Offset 0 sits in the top byte of a big-endian longword
    assign lane_ofs  = (sdmac_pkg::LANES - 1 - bo_q) * sdmac_pkg::DATA_W;
    assign lane_byte = head[lane_ofs +: sdmac_pkg::DATA_W];

    always_comb begin
        pack_nxt = pack_q;
        pack_nxt[lane_ofs +: sdmac_pkg::DATA_W] = scsi_d_i;
    end

    // Chip side commits its packed word, otherwise the memory side pushes
    assign push      = dp_ctl_i.inc_ni || (mem_wr_i && !full);
    assign pop       = dp_ctl_i.inc_no || (mem_rd_i && !empty);
    assign push_data = dp_ctl_i.inc_ni ? pack_nxt : mem_wdata_i;

    always_ff @(posedge BCLK) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= push_data;
        end
        if (dp_ctl_i.s2f) begin
            pack_q <= pack_nxt;
        end
        if (dp_ctl_i.s2cpu) begin
            cpu_d_q <= scsi_d_i;
        end
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            bo_q     <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
            // Shared by packing and unpacking and wraps after lane 3
            if (dp_ctl_i.inc_bo) begin
                bo_q <= bo_q + 1'b1;
            end
        end
    end

    always_comb begin
        if (dp_ctl_i.cpu2s) begin
            scsi_d_o = cpu_d_i;
        end else if (dp_ctl_i.f2s) begin
            scsi_d_o = lane_byte;
        end else begin
            scsi_d_o = '0;
        end
    end

    assign cpu_d_o     = cpu_d_q;
    assign mem_rdata_o = head;

    assign fifo_stat_o.full   = full;
    assign fifo_stat_o.empty  = empty;
    assign fifo_stat_o.bo_eq3 = (bo_q == sdmac_pkg::BO_W'(sdmac_pkg::LANES - 1));

    // Both FIFO sides must respect the status flags
    a_no_push_full: assert property (
        @(posedge BCLK) disable iff (!CRESET_)
        full |-> !(mem_wr_i || dp_ctl_i.inc_ni)
    );

    a_no_pop_empty: assert property (
        @(posedge BCLK) disable iff (!CRESET_)
        empty |-> !(mem_rd_i || dp_ctl_i.inc_no)
    );

endmodule

// ==== rtl/scsi_dma_top.sv ====
// SCSI DMA controller top level
// Cycle sequencer plus FIFO datapath with the memory side exposed as strobes
`timescale 1ns/1ns

module scsi_dma_top #(
    parameter int ACCESS_CYCLES = 3,
    parameter int FIFO_DEPTH    = 4
) (
    input  logic                             BCLK,
    input  logic                             CRESET_,
    // CPU register port
    input  logic                             cpu_req_i,
    input  logic                             cpu_rw_i,
    input  logic [sdmac_pkg::REG_ADDR_W-1:0] cpu_addr_i,
    input  logic [sdmac_pkg::DATA_W-1:0]     cpu_d_i,
    output logic                             set_dsack_o,
    output logic [sdmac_pkg::DATA_W-1:0]     cpu_d_o,
    // SCSI chip
    input  logic                             dma_dir_i,
    input  logic                             dreq_n_i,
    input  logic [sdmac_pkg::DATA_W-1:0]     scsi_d_i,
    output sdmac_pkg::scsi_bus_t             scsi_bus_o,
    output logic [sdmac_pkg::DATA_W-1:0]     scsi_d_o,
    // Memory side of the FIFO
    input  logic                             mem_wr_i,
    input  logic [sdmac_pkg::LWORD_W-1:0]    mem_wdata_i,
    input  logic                             mem_rd_i,
    output logic [sdmac_pkg::LWORD_W-1:0]    mem_rdata_o,
    output logic                             mem_full_o,
    output logic                             mem_empty_o
);

    sdmac_pkg::dp_ctl_t    dp_ctl;
    sdmac_pkg::fifo_stat_t fifo_stat;

    scsi_sm #(
        .ACCESS_CYCLES (ACCESS_CYCLES)
    ) u_scsi_sm (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .cpu_req_i   (cpu_req_i),
        .cpu_rw_i    (cpu_rw_i),
        .cpu_addr_i  (cpu_addr_i),
        .dma_dir_i   (dma_dir_i),
        .dreq_n_i    (dreq_n_i),
        .fifo_stat_i (fifo_stat),
        .scsi_bus_o  (scsi_bus_o),
        .dp_ctl_o    (dp_ctl),
        .set_dsack_o (set_dsack_o)
    );

    sdmac_datapath #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_datapath (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .dp_ctl_i    (dp_ctl),
        .scsi_d_i    (scsi_d_i),
        .cpu_d_i     (cpu_d_i),
        .mem_wr_i    (mem_wr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_rd_i    (mem_rd_i),
        .scsi_d_o    (scsi_d_o),
        .cpu_d_o     (cpu_d_o),
        .mem_rdata_o (mem_rdata_o),
        .fifo_stat_o (fifo_stat)
    );

    assign mem_full_o  = fifo_stat.full;
    assign mem_empty_o = fifo_stat.empty;

endmodule

// ==== dv/scsi_chip_model.sv ====
// Behavioral SCSI protocol chip
// Register file for CPU cycles, LCG byte source and byte sink for DMA
`timescale 1ns/1ns

module scsi_chip_model (
    input  logic                  BCLK,
    input  logic                  CRESET_,
    input  sdmac_pkg::scsi_bus_t  bus_i,
    input  logic [7:0]            d_i,
    input  logic                  dma_run_i,
    input  logic [15:0]           dma_limit_i,
    output logic [7:0]            d_o,
    output logic                  dreq_n_o,
    output logic [15:0]           xfer_cnt_o
);

    logic [7:0]  regs [16];
    logic [7:0]  rx_mem [64];
    logic [7:0]  rx_last;
    logic [31:0] lcg_q;
    logic [31:0] lcg_nxt;
    logic        dack_q;
    logic        re_q;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign lcg_nxt = lcg_step(lcg_q);

    // Register read data, otherwise the next DMA byte
    assign d_o = (bus_i.cs && bus_i.re) ? regs[bus_i.addr] : lcg_nxt[23:16];

    // Request stays asserted until the byte budget is used up
    assign dreq_n_o = !(dma_run_i && (xfer_cnt_o != dma_limit_i));

    // Bus strobes are registered on the rising edge, sample on the falling one
    always @(negedge BCLK) begin
        if (bus_i.cs && bus_i.we) begin
            regs[bus_i.addr] <= d_i;
        end
        if (bus_i.dack && bus_i.we) begin
            rx_last <= d_i;
        end
        if (dack_q && !bus_i.dack && !re_q) begin
            rx_mem[xfer_cnt_o[5:0]] <= rx_last;
        end
    end

    always_ff @(negedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            lcg_q      <= 32'd62;
            dack_q     <= 1'b0;
            re_q       <= 1'b0;
            xfer_cnt_o <= '0;
        end else begin
            dack_q <= bus_i.dack;
            re_q   <= bus_i.re;
            // End of a dack pulse completes one byte
            if (dack_q && !bus_i.dack) begin
                xfer_cnt_o <= xfer_cnt_o + 1'b1;
                if (re_q) begin
                    lcg_q <= lcg_nxt;
                end
            end
        end
    end

endmodule

// ==== dv/tb_scsi_dma_top.sv ====
// Testbench for the SCSI DMA controller
// Table driven CPU, DMA and FIFO tests against a behavioral chip model
`timescale 1ns/1ns

module tb_scsi_dma_top;

    localparam int ACCESS_CYCLES = 3;
    localparam int FIFO_DEPTH    = 4;
    localparam int TIMEOUT       = 400;
    localparam int N_MAX         = 32;

    typedef enum {OP_RESET, OP_CPU_WR, OP_CPU_RD, OP_S2F, OP_F2S,
                  OP_PUSH, OP_POP, OP_BP, OP_PRIO} op_e;

    logic                 BCLK;
    logic                 CRESET_;
    logic                 cpu_req;
    logic                 cpu_rw;
    logic [3:0]           cpu_addr;
    logic [7:0]           cpu_d;
    logic                 set_dsack;
    logic [7:0]           cpu_rd;
    logic                 dma_dir;
    logic                 dreq_n;
    logic [7:0]           chip_d;
    sdmac_pkg::scsi_bus_t scsi_bus;
    logic [7:0]           scsi_d;
    logic                 mem_wr;
    logic [31:0]          mem_wdata;
    logic                 mem_rd;
    logic [31:0]          mem_rdata;
    logic                 mem_full;
    logic                 mem_empty;
    logic                 dma_run;
    logic [15:0]          dma_limit;
    logic [15:0]          xfer_cnt;

    string       t_name [N_MAX];
    op_e         t_op [N_MAX];
    logic [31:0] t_arg [N_MAX];
    logic [31:0] t_data [N_MAX];
    logic [31:0] t_exp [N_MAX];
    int          n_tests;
    string       cur_name;
    int          test_err;
    int          pass_cnt;
    int          fail_cnt;
    logic [31:0] lcg_state;
    logic [7:0]  s2f_q [$];
    logic [7:0]  f2s_q [$];

    scsi_dma_top DUT (
        .BCLK (BCLK), .CRESET_ (CRESET_),
        .cpu_req_i (cpu_req), .cpu_rw_i (cpu_rw), .cpu_addr_i (cpu_addr),
        .cpu_d_i (cpu_d), .set_dsack_o (set_dsack), .cpu_d_o (cpu_rd),
        .dma_dir_i (dma_dir), .dreq_n_i (dreq_n), .scsi_d_i (chip_d),
        .scsi_bus_o (scsi_bus), .scsi_d_o (scsi_d),
        .mem_wr_i (mem_wr), .mem_wdata_i (mem_wdata), .mem_rd_i (mem_rd),
        .mem_rdata_o (mem_rdata), .mem_full_o (mem_full), .mem_empty_o (mem_empty)
    );

    scsi_chip_model chip (
        .BCLK (BCLK), .CRESET_ (CRESET_), .bus_i (scsi_bus), .d_i (scsi_d),
        .dma_run_i (dma_run), .dma_limit_i (dma_limit), .d_o (chip_d),
        .dreq_n_o (dreq_n), .xfer_cnt_o (xfer_cnt)
    );

    initial begin
        BCLK = 1'b0;
        forever #2 BCLK = ~BCLK;
    end

    function automatic string state_name(input sdmac_pkg::sm_state_e s);
        case (s)
            sdmac_pkg::IDLE:     return "IDLE";
            sdmac_pkg::CPU_ACC:  return "CPU_ACC";
            sdmac_pkg::CPU_ACK:  return "CPU_ACK";
            sdmac_pkg::CPU_WAIT: return "CPU_WAIT";
            sdmac_pkg::DMA_ACC:  return "DMA_ACC";
            sdmac_pkg::DMA_REC:  return "DMA_REC";
            default:             return "?";
        endcase
    endfunction

    task automatic add_test(input string name, input op_e op, input logic [31:0] arg,
                            input logic [31:0] data, input logic [31:0] exp);
        t_name[n_tests] = name;
        t_op[n_tests]   = op;
        t_arg[n_tests]  = arg;
        t_data[n_tests] = data;
        t_exp[n_tests]  = exp;
        n_tests++;
    endtask

    // One step of the chip's byte source generator
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Chip byte stream as the LCG with seed 62 produces it
    task automatic predict_bytes(input int n);
        for (int i = 0; i < n; i++) begin
            lcg_state = lcg_next(lcg_state);
            s2f_q.push_back(lcg_state[23:16]);
        end
    endtask

    task automatic check_val(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s %s: expected %h actual %h (state %s)", cur_name, what,
                     exp, act, state_name(DUT.u_scsi_sm.state_q));
            test_err++;
        end
    endtask

    task automatic check_true(input logic ok, input string msg);
        assert (ok === 1'b1) else begin
            $display("%s: %s", cur_name, msg);
            test_err++;
        end
    endtask

    task automatic time_out(input string what);
        $display("%s: timed out waiting for %s", cur_name, what);
        $display("test failed");
        $finish;
    endtask

    // All tasks are entered on a falling edge and return on one
    task automatic cpu_access(input logic rw, input logic [31:0] addr,
                              input logic [31:0] data, output logic [7:0] rd);
        int n;
        n        = 0;
        cpu_req  = 1'b1;
        cpu_rw   = rw;
        cpu_addr = addr[3:0];
        cpu_d    = data[7:0];
        do begin
            @(negedge BCLK);
            n++;
            if (n > TIMEOUT) time_out("set_dsack_o");
            check_true(!scsi_bus.dack, "dack seen during a CPU access");
        end while (!set_dsack);
        check_val("access latency", ACCESS_CYCLES + 3, n);
        rd      = cpu_rd;
        cpu_req = 1'b0;
    endtask

    task automatic start_dma(input logic dir, input int count);
        dma_dir   = dir;
        dma_limit = xfer_cnt + count;
        dma_run   = 1'b1;
    endtask

    task automatic wait_xfer(input logic [15:0] target);
        int n;
        n = 0;
        while (xfer_cnt != target) begin
            @(negedge BCLK);
            n++;
            if (n > TIMEOUT) time_out("DMA bytes");
        end
    endtask

    task automatic pop_check();
        int n;
        logic [31:0] exp;
        n = 0;
        while (mem_empty) begin
            @(negedge BCLK);
            n++;
            if (n > TIMEOUT) time_out("FIFO data");
        end
        for (int i = 0; i < 4; i++) begin
            exp = {exp[23:0], s2f_q.pop_front()};
        end
        check_val("mem_rdata_o", exp, mem_rdata);
        mem_rd = 1'b1;
        @(negedge BCLK);
        mem_rd = 1'b0;
    endtask

    task automatic push_word(input logic [31:0] data);
        int n;
        n = 0;
        while (mem_full) begin
            @(negedge BCLK);
            n++;
            if (n > TIMEOUT) time_out("FIFO space");
        end
        mem_wr    = 1'b1;
        mem_wdata = data;
        for (int i = 3; i >= 0; i--) begin
            f2s_q.push_back(data[i*8 +: 8]);
        end
        @(negedge BCLK);
        mem_wr = 1'b0;
    endtask

    task automatic run_test(input int i);
        logic [7:0]  rd;
        logic [15:0] base;
        base = xfer_cnt;
        case (t_op[i])
            OP_RESET: begin
                check_val("scsi_bus_o", 0, 32'(scsi_bus));
                check_val("set_dsack_o", 0, set_dsack);
                check_val("mem_empty_o", 1, mem_empty);
                check_val("mem_full_o", 0, mem_full);
            end
            OP_CPU_WR: cpu_access(1'b0, t_arg[i], t_data[i], rd);
            OP_CPU_RD: begin
                cpu_access(1'b1, t_arg[i], 0, rd);
                check_val("cpu_d_o", t_exp[i], rd);
            end
            OP_S2F: begin
                start_dma(1'b0, t_arg[i]);
                predict_bytes(t_arg[i]);
                wait_xfer(base + t_arg[i]);
                dma_run = 1'b0;
            end
            OP_F2S: begin
                start_dma(1'b1, t_arg[i]);
                wait_xfer(base + t_arg[i]);
                dma_run = 1'b0;
                for (int k = 0; k < t_arg[i]; k++) begin
                    check_val("chip byte", f2s_q.pop_front(), chip.rx_mem[(base + k) % 64]);
                end
                check_val("mem_empty_o", t_exp[i], mem_empty);
            end
            OP_PUSH: push_word(t_data[i]);
            OP_POP:  pop_check();
            OP_BP: begin
                // Request held low for more bytes than the FIFO can take
                start_dma(1'b0, 4 * FIFO_DEPTH + 4);
                predict_bytes(4 * FIFO_DEPTH + 4);
                for (int n = 0; !mem_full; n++) begin
                    @(negedge BCLK);
                    if (n > TIMEOUT) time_out("mem_full_o");
                end
                repeat (40) begin
                    @(negedge BCLK);
                    check_true(!scsi_bus.dack, "dack seen while the FIFO is full");
                end
                check_val("bytes before full", 4 * FIFO_DEPTH, xfer_cnt - base);
                pop_check();
                wait_xfer(base + 4 * FIFO_DEPTH + 4);
                dma_run = 1'b0;
            end
            OP_PRIO: begin
                start_dma(1'b0, t_data[i]);
                predict_bytes(t_data[i]);
                cpu_access(1'b1, t_arg[i], 0, rd);
                check_val("cpu_d_o", t_exp[i], rd);
                wait_xfer(base + t_data[i]);
                dma_run = 1'b0;
            end
            default: check_true(1'b0, "unknown table operation");
        endcase
    endtask

    initial begin
        CRESET_   = 1'b0;
        cpu_req   = 1'b0;
        cpu_rw    = 1'b0;
        cpu_addr  = '0;
        cpu_d     = '0;
        dma_dir   = 1'b0;
        mem_wr    = 1'b0;
        mem_wdata = '0;
        mem_rd    = 1'b0;
        dma_run   = 1'b0;
        dma_limit = '0;
        lcg_state = 32'd62;
        n_tests   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        add_test("reset", OP_RESET, 0, 0, 0);
        add_test("wr_1", OP_CPU_WR, 1, 8'ha5, 0);
        add_test("wr_3", OP_CPU_WR, 3, 8'h3c, 0);
        add_test("wr_7", OP_CPU_WR, 7, 8'hf0, 0);
        add_test("wr_12", OP_CPU_WR, 12, 8'h81, 0);
        add_test("rd_1", OP_CPU_RD, 1, 0, 8'ha5);
        add_test("rd_3", OP_CPU_RD, 3, 0, 8'h3c);
        add_test("rd_7", OP_CPU_RD, 7, 0, 8'hf0);
        add_test("rd_12", OP_CPU_RD, 12, 0, 8'h81);
        add_test("s2f_8", OP_S2F, 8, 0, 0);
        add_test("s2f_pop0", OP_POP, 0, 0, 0);
        add_test("s2f_pop1", OP_POP, 0, 0, 0);
        add_test("push0", OP_PUSH, 0, 32'h11223344, 0);
        add_test("push1", OP_PUSH, 0, 32'h55667788, 0);
        add_test("f2s_8", OP_F2S, 8, 0, 1);
        add_test("backpressure", OP_BP, 0, 0, 0);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            add_test($sformatf("bp_pop%0d", i), OP_POP, 0, 0, 0);
        end
        add_test("cpu_priority", OP_PRIO, 3, 8, 8'h3c);
        add_test("prio_pop0", OP_POP, 0, 0, 0);
        add_test("prio_pop1", OP_POP, 0, 0, 0);
        repeat (5) @(posedge BCLK);
        @(negedge BCLK);
        CRESET_ = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            cur_name = t_name[i];
            test_err = 0;
            @(negedge BCLK);
            run_test(i);
            if (test_err == 0) begin
                pass_cnt++;
                $display("[PASS] %s", cur_name);
            end else begin
                fail_cnt++;
                $display("[FAIL] %s", cur_name);
            end
        end
        $display("summary: %0d run, %0d ok, %0d bad", n_tests, pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== scsi_dma_top.f ====
rtl/sdmac_pkg.sv
rtl/scsi_sm.sv
rtl/sdmac_datapath.sv
rtl/scsi_dma_top.sv
dv/scsi_chip_model.sv
dv/tb_scsi_dma_top.sv

// ==== Bender.yml ====
package:
  name: scsi_dma

sources:
  - rtl/sdmac_pkg.sv
  - rtl/scsi_sm.sv
  - rtl/sdmac_datapath.sv
  - rtl/scsi_dma_top.sv
  - target: simulation
    files:
      - dv/scsi_chip_model.sv
      - dv/tb_scsi_dma_top.sv
